//--- design/cache_bus_pkg.sv
package cache_bus_pkg;

    ////////////////////
    // Hart side
    ////////////////////

    // Request fields that stay constant while the cache is busy
    // The read and write enables travel on their own ports
    typedef struct packed {
        cache_geom_pkg::cache_addr_u addr;  // Word-aligned request address
        logic [3:0]                  mask;  // One bit per byte lane
        logic [31:0]                 wdata; // Store data, lanes already in place
    } cache_req_t;

    ////////////////////
    // Memory side
    ////////////////////

    // Word-granular request toward the backing memory
    typedef struct packed {
        logic        ren;   // Read one word, answered later with valid
        logic        wen;   // Write one word, no response
        logic [31:0] addr;  // Word address with the low two bits at zero
        logic [31:0] wdata; // Full merged word for write-through
    } mem_req_t;

endpackage

//--- design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  cache_bus_pkg::cache_req_t i_req,
    input  logic                      i_req_ren,
    input  logic                      i_req_wen,
    input  logic                      i_hit,
    input  logic                      i_hit_way,
    input  logic                      i_victim_way,
    input  logic [31:0]               i_merged,      // Word the store writes through
    input  logic                      i_mem_ready,
    input  logic                      i_mem_valid,
    output cache_bus_pkg::mem_req_t   o_mem_req,
    output logic                      o_busy,
    output logic                      o_touch,
    output logic                      o_touch_way,
    output logic                      o_fill,
    output logic                      o_fill_way,
    output logic                      o_refill,
    output logic                      o_refill_way,
    output cache_geom_pkg::word_sel_t o_refill_beat,
    output logic                      o_store,
    output logic                      o_store_way,
    output logic                      o_rd_way
);
    typedef enum logic [2:0] {
        LOOKUP,        // Idle and serving hits
        REFILL_ISSUE,  // Waiting for ready to ask for the next line word
        REFILL_WAIT,   // Read outstanding
        WRITE_THROUGH, // Pending store and the memory write
        DONE           // Read miss result shown with busy low
    } state_t;

    state_t                    state_q;
    state_t                    state_d;
    logic                      op_wr_q;  // Miss came from a store that is not merged yet
    logic                      op_wr_d;
    logic                      way_q;    // Way the miss or store works on
    logic                      way_d;
    cache_geom_pkg::word_sel_t beat_q;   // Line word being fetched
    cache_geom_pkg::word_sel_t beat_d;

    ////////////////////
    // State registers
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= LOOKUP;
            op_wr_q <= 1'b0;
            way_q   <= 1'b0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            op_wr_q <= op_wr_d;
            way_q   <= way_d;
            beat_q  <= beat_d;
        end
    end

    ////////////////////
    // Next state and outputs
    ////////////////////

    always_comb begin
        state_d = state_q;
        op_wr_d = op_wr_q;
        way_d   = way_q;
        beat_d  = beat_q;

        // Strobes stay quiet unless a state raises them
        o_mem_req     = '0;
        o_busy        = 1'b0;
        o_touch       = 1'b0;
        o_touch_way   = i_hit_way;
        o_fill        = 1'b0;
        o_fill_way    = way_q;
        o_refill      = 1'b0;
        o_refill_way  = way_q;
        o_refill_beat = beat_q;
        o_store       = 1'b0;
        o_store_way   = way_q;
        o_rd_way      = way_q; // Latched way outside LOOKUP

        case (state_q)
            LOOKUP: begin
                o_rd_way    = i_hit_way;
                o_store_way = i_hit_way;
                if (i_req_ren || i_req_wen) begin
                    if (i_hit) begin
                        o_touch = 1'b1; // Either kind of hit makes the way MRU
                        if (i_req_wen) begin
                            o_store = 1'b1; // Cached copy merged at this edge
                            o_busy  = 1'b1;
                            way_d   = i_hit_way;
                            state_d = WRITE_THROUGH;
                        end
                    end else begin
                        // Miss of either kind refills the victim way from word 0
                        o_busy  = 1'b1;
                        op_wr_d = i_req_wen;
                        way_d   = i_victim_way;
                        beat_d  = '0;
                        state_d = REFILL_ISSUE;
                    end
                end
            end

            REFILL_ISSUE: begin
                o_busy = 1'b1;
                if (i_mem_ready) begin
                    o_mem_req.ren  = 1'b1;
                    o_mem_req.addr = {i_req.addr.l.base, beat_q, 2'b00};
                    state_d        = REFILL_WAIT;
                end
            end

            REFILL_WAIT: begin
                o_busy = 1'b1;
                if (i_mem_valid) begin
                    o_refill = 1'b1;
                    o_fill   = (beat_q == '0); // Tag and valid go in with the first word
                    beat_d   = beat_q + 1'b1;
                    if (&beat_q) begin
                        state_d = op_wr_q ? WRITE_THROUGH : DONE;
                    end else begin
                        state_d = REFILL_ISSUE;
                    end
                end
            end

            WRITE_THROUGH: begin
                o_busy = 1'b1;
                if (op_wr_q) begin
                    // Store after a write miss merges into the freshly filled line
                    o_store = 1'b1;
                    op_wr_d = 1'b0;
                end else if (i_mem_ready) begin
                    o_mem_req.wen   = 1'b1;
                    o_mem_req.addr  = {i_req.addr.l.base, i_req.addr.f.word, 2'b00};
                    o_mem_req.wdata = i_merged; // Cache already holds this word
                    state_d         = LOOKUP;
                end
            end

            DONE: begin
                state_d = LOOKUP; // o_rd_way still points at the filled way here
            end

            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    ////////////////////
    // Checks
    ////////////////////

    // Neither the hart nor this FSM may ask for a read and a write together
    a_one_enable: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_req_ren && i_req_wen) && !(o_mem_req.ren && o_mem_req.wen))
        else $error("Read and write enables both high on a bus");

    // Memory only samples requests while it is ready
    a_req_when_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_mem_req.ren || o_mem_req.wen) |-> i_mem_ready)
        else $error("Memory request raised with i_mem_ready low");

endmodule

//--- design/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
    input  logic                      i_clk,
    input  cache_bus_pkg::cache_req_t i_req,         // Address, mask and store data
    input  logic                      i_rd_way,      // Way to read the word from
    output logic [31:0]               o_rdata,       // Word at the request address
    output logic [31:0]               o_merged,      // Word with the store bytes merged in
    input  logic                      i_store,       // Write o_merged back
    input  logic                      i_store_way,
    input  logic                      i_refill,      // Write one word fetched from memory
    input  logic                      i_refill_way,
    input  cache_geom_pkg::word_sel_t i_refill_beat, // Word of the line being filled
    input  logic [31:0]               i_refill_data
);
    ////////////////////
    // Line storage
    ////////////////////

    // Two ways, each a full line per set
    logic [31:0] data_q [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS]
                        [cache_geom_pkg::WORDS_PER_LINE];

    cache_geom_pkg::set_idx_t  set_idx;
    cache_geom_pkg::word_sel_t word_sel;

    assign set_idx  = i_req.addr.f.set;
    assign word_sel = i_req.addr.f.word;

    // Hit data comes straight out of the array in the request cycle
    assign o_rdata = data_q[i_rd_way][set_idx][word_sel];

    ////////////////////
    // Byte merge
    ////////////////////

    // Any mask pattern works, each lane is taken on its own
    always_comb begin
        o_merged = o_rdata;
        for (int b = 0; b < 4; b++) begin
            if (i_req.mask[b]) begin
                o_merged[8*b +: 8] = i_req.wdata[8*b +: 8];
            end
        end
    end

    // Stores land on the requested word and refills walk the line by beat
    always_ff @(posedge i_clk) begin
        if (i_store) begin
            data_q[i_store_way][set_idx][word_sel] <= o_merged;
        end else if (i_refill) begin
            data_q[i_refill_way][set_idx][i_refill_beat] <= i_refill_data;
        end
    end

    // The controller finishes the refill before the pending store of a write miss
    a_store_xor_refill: assert property (@(posedge i_clk) !(i_store && i_refill))
        else $error("Store and refill both hit set %0d in one cycle", set_idx);

endmodule

//--- design/cache_geom_pkg.sv
package cache_geom_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    // 32 sets of two 16-byte ways give a 1 KiB cache
    localparam int OFFSET_BITS    = 4;  // Byte offset within a 16-byte line
    localparam int SET_BITS       = 5;  // Set index width
    localparam int NUM_SETS       = 32; // One set per index value
    localparam int WORDS_PER_LINE = 4;  // Four 32-bit words in a line
    localparam int WORD_SEL_BITS  = 2;  // Selects one word of the line
    localparam int TAG_BITS       = 23; // What is left of the 32-bit address
    localparam int NUM_WAYS       = 2;  // Two-way set-associative

    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

    // Address as the tag compare sees it
    typedef struct packed {
        tag_t       tag;      // Compared against both ways
        set_idx_t   set;      // Picks the set
        word_sel_t  word;     // Picks the word in the line
        logic [1:0] byte_off; // Always zero for word requests
    } addr_fields_t;

    // Address as the memory port sees it
    typedef struct packed {
        logic [31-OFFSET_BITS:0] base; // Line base, shared by all four words
        logic [OFFSET_BITS-1:0]  off;  // Offset inside the line
    } addr_line_t;

    // One request address, decoded either for lookup or for line access
    typedef union packed {
        addr_fields_t f;
        addr_line_t   l;
    } cache_addr_u;

endpackage

//--- design/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  cache_geom_pkg::cache_addr_u i_addr,       // Current hart address
    output logic                        o_hit,        // Tag matched in a valid way
    output logic                        o_hit_way,    // Way that matched
    output logic                        o_victim_way, // Way a miss would refill
    input  logic                        i_touch,      // Hit was used, mark MRU
    input  logic                        i_touch_way,
    input  logic                        i_fill,       // First refill beat of a line
    input  logic                        i_fill_way
);
    ////////////////////
    // State
    ////////////////////

    cache_geom_pkg::tag_t tag_q [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::NUM_SETS];
    logic [cache_geom_pkg::NUM_WAYS-1:0] valid_q [cache_geom_pkg::NUM_SETS];
    logic mru_q [cache_geom_pkg::NUM_SETS]; // Way touched last in each set

    cache_geom_pkg::set_idx_t            set_idx;
    logic [cache_geom_pkg::NUM_WAYS-1:0] set_valid;
    logic [cache_geom_pkg::NUM_WAYS-1:0] way_hit;

    assign set_idx   = i_addr.f.set;
    assign set_valid = valid_q[set_idx];

    ////////////////////
    // Lookup
    ////////////////////

    // Both ways are compared in parallel in the request cycle
    always_comb begin
        for (int w = 0; w < cache_geom_pkg::NUM_WAYS; w++) begin
            way_hit[w] = set_valid[w] && (tag_q[w][set_idx] == i_addr.f.tag);
        end
    end

    assign o_hit     = |way_hit;
    assign o_hit_way = way_hit[1]; // Only meaningful together with o_hit

    // An empty way is always taken first, way 0 before way 1
    always_comb begin
        if (!set_valid[0]) begin
            o_victim_way = 1'b0;
        end else if (!set_valid[1]) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = ~mru_q[set_idx]; // Full set evicts the way not used last
        end
    end

    ////////////////////
    // Update
    ////////////////////

    // The tag is written once per refill, on its first beat
    always_ff @(posedge i_clk) begin
        if (i_fill) begin
            tag_q[i_fill_way][set_idx] <= i_addr.f.tag;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                mru_q[s]   <= 1'b0; // All sets start with way 0 as MRU
            end
        end else if (i_fill) begin
            valid_q[set_idx][i_fill_way] <= 1'b1;
            mru_q[set_idx]               <= i_fill_way; // New line counts as used
        end else if (i_touch) begin
            mru_q[set_idx] <= i_touch_way;
        end
    end

    // A line is only ever allocated into the victim way, so a tag may never live twice in a set
    a_one_hit_way: assert property (@(posedge i_clk) disable iff (i_rst)
        !(way_hit[0] && way_hit[1]))
        else $error("Tag %h hit in both ways of set %0d", i_addr.f.tag, set_idx);

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic        i_clk,
    input  logic        i_rst,
    // Backing memory port
    input  logic        i_mem_ready,
    output logic [31:0] o_mem_addr,
    output logic        o_mem_ren,
    output logic        o_mem_wen,
    output logic [31:0] o_mem_wdata,
    input  logic [31:0] i_mem_rdata,
    input  logic        i_mem_valid,
    // Hart port
    output logic        o_busy,
    input  logic [31:0] i_req_addr,
    input  logic        i_req_ren,
    input  logic        i_req_wen,
    input  logic [ 3:0] i_req_mask,
    input  logic [31:0] i_req_wdata,
    output logic [31:0] o_res_rdata
);
    cache_bus_pkg::cache_req_t req;
    cache_bus_pkg::mem_req_t   mem_req;

    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    logic                      touch;
    logic                      touch_way;
    logic                      fill;
    logic                      fill_way;
    logic                      refill;
    logic                      refill_way;
    cache_geom_pkg::word_sel_t refill_beat;
    logic                      store;
    logic                      store_way;
    logic                      rd_way;
    logic [31:0]               merged;

    // Hart request fields are held by the hart for the whole miss
    assign req.addr  = i_req_addr;
    assign req.mask  = i_req_mask;
    assign req.wdata = i_req_wdata;

    assign o_mem_addr  = mem_req.addr;
    assign o_mem_ren   = mem_req.ren;
    assign o_mem_wen   = mem_req.wen;
    assign o_mem_wdata = mem_req.wdata;

    cache_ctrl u_ctrl (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_req(req), .i_req_ren(i_req_ren), .i_req_wen(i_req_wen),
        .i_hit(hit), .i_hit_way(hit_way), .i_victim_way(victim_way),
        .i_merged(merged), .i_mem_ready(i_mem_ready), .i_mem_valid(i_mem_valid),
        .o_mem_req(mem_req), .o_busy(o_busy),
        .o_touch(touch), .o_touch_way(touch_way),
        .o_fill(fill), .o_fill_way(fill_way),
        .o_refill(refill), .o_refill_way(refill_way), .o_refill_beat(refill_beat),
        .o_store(store), .o_store_way(store_way), .o_rd_way(rd_way)
    );

    cache_tag_store u_tag_store (
        .i_clk(i_clk), .i_rst(i_rst), .i_addr(req.addr),
        .o_hit(hit), .o_hit_way(hit_way), .o_victim_way(victim_way),
        .i_touch(touch), .i_touch_way(touch_way),
        .i_fill(fill), .i_fill_way(fill_way)
    );

    cache_data_store u_data_store (
        .i_clk(i_clk), .i_req(req), .i_rd_way(rd_way),
        .o_rdata(o_res_rdata), .o_merged(merged),
        .i_store(store), .i_store_way(store_way),
        .i_refill(refill), .i_refill_way(refill_way),
        .i_refill_beat(refill_beat), .i_refill_data(i_mem_rdata)
    );

endmodule

//--- tests/cache_checker.sv
`timescale 1ns/1ps

module cache_checker #(
    parameter logic [31:0] FILL_XOR = 32'h0,
    parameter int          MEM_AW   = 12
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_req_ren,
    input  logic        i_req_wen,
    input  logic [31:0] i_req_addr,
    input  logic [ 3:0] i_req_mask,
    input  logic [31:0] i_req_wdata,
    input  logic        i_busy,
    input  logic [31:0] i_res_rdata,
    input  logic [31:0] i_mem_addr,
    input  logic        i_mem_ren,
    input  logic        i_mem_wen,
    input  logic [31:0] i_mem_wdata,
    input  logic        i_mem_ready,
    input  logic [ 7:0] i_test_id,   // Table entry in flight, 0 is the reset check
    input  logic [31:0] i_exp_rdata, // Load result the table expects
    input  logic [ 2:0] i_exp_reads, // Memory reads the table expects
    output logic [15:0] o_tests,
    output logic [15:0] o_errors
);
    logic [31:0]                 shadow [2**MEM_AW]; // What memory must hold after each store
    cache_geom_pkg::cache_addr_u op_addr;
    int                          op_idx;
    logic                        op_active;
    logic                        op_wr;
    logic                        rst_checked;
    logic [2:0]                  rd_cnt;
    logic [2:0]                  wr_cnt;
    logic [15:0]                 err_at_start;
    logic [31:0]                 exp_addr;

    initial begin
        o_tests     = '0;
        o_errors    = '0;
        op_active   = 1'b0;
        rst_checked = 1'b0;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            shadow[i] = i ^ FILL_XOR; // Same fill rule as the memory model
        end
    end

    // Byte lanes with a mask bit come from the store data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [3:0] mask,
                                                input logic [31:0] wdata);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        o_errors = o_errors + 1'b1;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR t=%0t %s", $time, what);
        o_errors = o_errors + 1'b1;
    endtask

    ////////////////////
    // Port watching
    ////////////////////

    // All ports are sampled mid-cycle, where every driver has settled
    always @(negedge i_clk) begin
        if (i_rst) begin
            op_active = 1'b0;
        end else begin
            if (!rst_checked) begin
                rst_checked  = 1'b1;
                err_at_start = o_errors;
                if (i_busy || i_mem_ren || i_mem_wen) begin
                    report_problem("o_busy or a memory enable is high right after reset");
                end
                o_tests = o_tests + 1'b1;
                if (o_errors == err_at_start) $display("test 0 reset state: ok");
                else $display("test 0 reset state: errors");
            end

            // A new hart access opens a test
            if (!op_active && (i_req_ren || i_req_wen)) begin
                op_active    = 1'b1;
                op_wr        = i_req_wen;
                op_addr      = i_req_addr;
                op_idx       = i_req_addr[MEM_AW+1:2];
                rd_cnt       = '0;
                wr_cnt       = '0;
                err_at_start = o_errors;
                if (i_req_addr[31:MEM_AW+2] != '0) begin
                    report_problem("request address lies outside the shadow memory");
                end
                if (op_wr) begin
                    shadow[op_idx] = merge_bytes(shadow[op_idx], i_req_mask, i_req_wdata);
                end
                if (!op_wr && i_exp_reads == 3'd0 && i_busy) begin
                    report_problem("read that should hit raised o_busy");
                end
            end

            // Memory traffic accepted in this cycle
            if (i_mem_ready && (i_mem_ren || i_mem_wen)) begin
                if (!op_active) begin
                    report_problem("memory request with no hart access in flight");
                end else if (i_mem_ren) begin
                    exp_addr = {op_addr.l.base, rd_cnt[1:0], 2'b00}; // Refill walks words 0 to 3
                    if (rd_cnt >= 3'd4) begin
                        report_problem("more than four memory reads in one access");
                    end else if (i_mem_addr !== exp_addr) begin
                        report_mismatch("o_mem_addr", exp_addr, i_mem_addr);
                    end
                    rd_cnt = rd_cnt + 1'b1;
                end else begin
                    exp_addr = {op_addr.l.base, op_addr.f.word, 2'b00};
                    if (!op_wr) report_problem("memory write during a read access");
                    if (i_mem_addr !== exp_addr) begin
                        report_mismatch("o_mem_addr", exp_addr, i_mem_addr);
                    end
                    if (i_mem_wdata !== shadow[op_idx]) begin
                        report_mismatch("o_mem_wdata", shadow[op_idx], i_mem_wdata);
                    end
                    wr_cnt = wr_cnt + 1'b1;
                end
            end

            // Busy low closes the test, in the request cycle for a hit
            if (op_active && !i_busy) begin
                if (!op_wr) begin
                    if (i_res_rdata !== i_exp_rdata) begin
                        report_mismatch("o_res_rdata", i_exp_rdata, i_res_rdata);
                    end
                    if (shadow[op_idx] !== i_exp_rdata) begin
                        report_problem("table and shadow memory disagree on the read word");
                    end
                end
                if (rd_cnt != i_exp_reads) begin
                    report_problem($sformatf("saw %0d memory reads where %0d belong",
                                             rd_cnt, i_exp_reads));
                end
                if (wr_cnt != {2'b00, op_wr}) begin
                    report_problem($sformatf("saw %0d memory writes for one access", wr_cnt));
                end
                o_tests   = o_tests + 1'b1;
                op_active = 1'b0;
                if (o_errors == err_at_start) begin
                    $display("test %0d %s %h: ok", i_test_id,
                             op_wr ? "write" : "read ", op_addr);
                end else begin
                    $display("test %0d %s %h: errors", i_test_id,
                             op_wr ? "write" : "read ", op_addr);
                end
            end
        end
    end

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
    localparam logic [31:0] SEED     = 32'hd61208d7;
    localparam logic [31:0] FILL_XOR = 32'h5a5a_0000; // Memory word is its word address XOR this
    localparam int          MEM_AW   = 12;            // 4096 words of backing memory
    localparam int          TIMEOUT  = 200;           // Cycles one access may keep o_busy high

    typedef struct packed {
        logic        wr;    // Store when set, load otherwise
        logic [31:0] addr;
        logic [3:0]  mask;
        logic [31:0] wdata;
        logic [31:0] rdata; // Expected load word
        logic [2:0]  reads; // Memory reads the access must cause
    } entry_t;

    logic        clk;
    logic        rst;
    logic        req_ren;
    logic        req_wen;
    logic [31:0] req_addr;
    logic [ 3:0] req_mask;
    logic [31:0] req_wdata;
    logic        busy;
    logic [31:0] res_rdata;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_valid;
    logic [ 7:0] test_id;
    logic [31:0] exp_rdata;
    logic [ 2:0] exp_reads;
    logic [15:0] tests;
    logic [15:0] errors;
    logic        timed_out;
    logic        run_ok;
    entry_t      tbl[$];

    always #2 clk = ~clk; // 4 ns period

    cache_top u_dut (
        .i_clk(clk), .i_rst(rst),
        .i_mem_ready(mem_ready), .o_mem_addr(mem_addr), .o_mem_ren(mem_ren),
        .o_mem_wen(mem_wen), .o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata),
        .i_mem_valid(mem_valid), .o_busy(busy), .i_req_addr(req_addr),
        .i_req_ren(req_ren), .i_req_wen(req_wen), .i_req_mask(req_mask),
        .i_req_wdata(req_wdata), .o_res_rdata(res_rdata)
    );

    mem_model #(.SEED(SEED), .FILL_XOR(FILL_XOR), .MEM_AW(MEM_AW)) u_mem (
        .i_clk(clk), .i_rst(rst), .i_addr(mem_addr), .i_ren(mem_ren), .i_wen(mem_wen),
        .i_wdata(mem_wdata), .o_ready(mem_ready), .o_rdata(mem_rdata), .o_valid(mem_valid)
    );

    cache_checker #(.FILL_XOR(FILL_XOR), .MEM_AW(MEM_AW)) u_checker (
        .i_clk(clk), .i_rst(rst), .i_req_ren(req_ren), .i_req_wen(req_wen),
        .i_req_addr(req_addr), .i_req_mask(req_mask), .i_req_wdata(req_wdata),
        .i_busy(busy), .i_res_rdata(res_rdata), .i_mem_addr(mem_addr),
        .i_mem_ren(mem_ren), .i_mem_wen(mem_wen), .i_mem_wdata(mem_wdata),
        .i_mem_ready(mem_ready), .i_test_id(test_id), .i_exp_rdata(exp_rdata),
        .i_exp_reads(exp_reads), .o_tests(tests), .o_errors(errors)
    );

    task automatic add_read(input logic [31:0] addr, input logic [31:0] rdata,
                            input logic [2:0] reads);
        entry_t e;
        e = '{wr: 1'b0, addr: addr, mask: 4'h0, wdata: 32'h0, rdata: rdata, reads: reads};
        tbl.push_back(e);
    endtask

    task automatic add_write(input logic [31:0] addr, input logic [3:0] mask,
                             input logic [31:0] wdata, input logic [2:0] reads);
        entry_t e;
        e = '{wr: 1'b1, addr: addr, mask: mask, wdata: wdata, rdata: 32'h0, reads: reads};
        tbl.push_back(e);
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        add_read (32'h0000_0104, 32'h5a5a_0041, 3'd4);        // Cold miss in set 16
        add_read (32'h0000_0100, 32'h5a5a_0040, 3'd0);        // Same line hits
        add_read (32'h0000_010c, 32'h5a5a_0043, 3'd0);
        add_write(32'h0000_0104, 4'b0001, 32'h0000_00a1, 3'd0); // Byte store
        add_read (32'h0000_0104, 32'h5a5a_00a1, 3'd0);
        add_write(32'h0000_0108, 4'b1100, 32'hbeef_0000, 3'd0); // Upper half-word
        add_read (32'h0000_0108, 32'hbeef_0042, 3'd0);
        add_write(32'h0000_010c, 4'b1111, 32'h1234_5678, 3'd0); // Full word
        add_read (32'h0000_010c, 32'h1234_5678, 3'd0);
        add_write(32'h0000_0100, 4'b0110, 32'h00c3_d400, 3'd0); // Middle lanes only
        add_read (32'h0000_0100, 32'h5ac3_d440, 3'd0);
        add_write(32'h0000_0228, 4'b0010, 32'h0000_7700, 3'd4); // Write miss refills first
        add_read (32'h0000_0228, 32'h5a5a_778a, 3'd0);
        add_read (32'h0000_0220, 32'h5a5a_0088, 3'd0);
        add_read (32'h0000_022c, 32'h5a5a_008b, 3'd0);
        // Set 5 with lines A 0x050, B 0x250 and C 0x450
        add_read (32'h0000_0050, 32'h5a5a_0014, 3'd4);        // A into way 0
        add_read (32'h0000_0254, 32'h5a5a_0095, 3'd4);        // B into way 1
        add_read (32'h0000_0058, 32'h5a5a_0016, 3'd0);        // A becomes MRU
        add_read (32'h0000_045c, 32'h5a5a_0117, 3'd4);        // C evicts B
        add_read (32'h0000_005c, 32'h5a5a_0017, 3'd0);        // A survived
        add_read (32'h0000_0250, 32'h5a5a_0094, 3'd4);        // B is gone
        add_read (32'h0000_0450, 32'h5a5a_0114, 3'd4);        // C lost to B in turn
        // Evicting the 0x100 line shows what was written through
        add_read (32'h0000_0300, 32'h5a5a_00c0, 3'd4);
        add_read (32'h0000_0500, 32'h5a5a_0140, 3'd4);
        add_read (32'h0000_0104, 32'h5a5a_00a1, 3'd4);
    endtask

    // One access, pulsed for a cycle, then held until o_busy is low
    task automatic apply_entry(input int idx);
        entry_t e;
        int     cycles;
        e = tbl[idx];
        @(posedge clk);
        req_ren   <= !e.wr;
        req_wen   <= e.wr;
        req_addr  <= e.addr;
        req_mask  <= e.mask;
        req_wdata <= e.wdata;
        test_id   <= idx + 1;
        exp_rdata <= e.rdata;
        exp_reads <= e.reads;
        @(posedge clk);
        req_ren <= 1'b0;
        req_wen <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("Timeout: o_busy still high %0d cycles into test %0d", TIMEOUT, idx + 1);
            timed_out = 1'b1;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        req_ren   = 1'b0;
        req_wen   = 1'b0;
        req_addr  = '0;
        req_mask  = '0;
        req_wdata = '0;
        test_id   = '0;
        exp_rdata = '0;
        exp_reads = '0;
        timed_out = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < tbl.size(); i++) begin
            if (!timed_out) apply_entry(i);
        end
        repeat (2) @(negedge clk); // Checker logs the last access first
        run_ok = !timed_out && errors == 0 && tests == tbl.size() + 1;
        if (!timed_out && tests != tbl.size() + 1) begin
            $display("Checker logged %0d tests where %0d were run", tests, tbl.size() + 1);
        end
        $display("Summary: %0d tests checked, %0d errors", tests, errors);
        if (run_ok) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] SEED     = 32'h0,
    parameter logic [31:0] FILL_XOR = 32'h0,
    parameter int          MEM_AW   = 12
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [31:0] i_addr,
    input  logic        i_ren,
    input  logic        i_wen,
    input  logic [31:0] i_wdata,
    output logic        o_ready,
    output logic [31:0] o_rdata,
    output logic        o_valid
);
    logic [31:0]       mem [2**MEM_AW]; // Word array, indexed by the word address
    integer            seed;
    logic              pending;         // One read in flight at most
    logic [2:0]        delay;           // Cycles left before the read answers
    logic [MEM_AW-1:0] pend_idx;

    initial begin
        seed     = SEED;
        o_ready  = 1'b0;
        o_rdata  = '0;
        o_valid  = 1'b0;
        pending  = 1'b0;
        delay    = '0;
        pend_idx = '0;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            mem[i] = i ^ FILL_XOR; // Every word differs, so a wrong address shows up
        end
    end

    always @(posedge i_clk) begin
        o_valid <= 1'b0; // Valid is a single-cycle pulse
        if (i_rst) begin
            o_ready <= 1'b0;
            pending <= 1'b0;
        end else begin
            o_ready <= ($random(seed) & 3) != 0; // Ready drops about one cycle in four
            if (pending) begin
                if (delay == 3'd1) begin
                    o_valid <= 1'b1;
                    o_rdata <= mem[pend_idx];
                    pending <= 1'b0;
                end else begin
                    delay <= delay - 1'b1;
                end
            end
            // Requests count only when ready was high in the same cycle
            if (o_ready && i_ren) begin
                pending  <= 1'b1;
                delay    <= 3'd1 + ($random(seed) & 3); // Answer after 1 to 4 cycles
                pend_idx <= i_addr[MEM_AW+1:2];
            end
            if (o_ready && i_wen) begin
                mem[i_addr[MEM_AW+1:2]] <= i_wdata;
            end
        end
    end

endmodule

//--- verilog.f
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_ctrl.sv
design/cache_top.sv
tests/mem_model.sv
tests/cache_checker.sv
tests/cache_tb.sv
